// ==== verilog.f ====
source/hacd_pkg.sv
source/hacd_fifo.sv
source/hacd_cpu_stall.sv
source/hacd_ctrl_unit.sv
source/hacd_mem_mux.sv
source/hacd_core.sv
testbench/hacd_core_assertions.sv
testbench/hacd_core_tb.sv

// ==== Bender.yml ====
package:
  name: hacd_core

sources:
  # design, in compile order
  - files:
      - source/hacd_pkg.sv
      - source/hacd_fifo.sv
      - source/hacd_cpu_stall.sv
      - source/hacd_ctrl_unit.sv
      - source/hacd_mem_mux.sv
      - source/hacd_core.sv

  # testbench with bound assertions, top module hacd_core_tb
  - target: test
    files:
      - testbench/hacd_core_assertions.sv
      - testbench/hacd_core_tb.sv

// ==== testbench/hacd_core_tb.sv ====
//////////////////////////////////////////////////////////////////////
// hacd core testbench
// bring-up table writes, cpu stall until init done, address rebase,
// in-order read data under back-pressure, hawk inactive mode
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module hacd_core_tb;

   localparam int N_TRANS        = 200;      // cpu transactions per phase
   localparam int TIMEOUT_CYCLES = 20000;

   logic        clk_i;
   logic        rst_n_i;
   logic        uart_boot_en_i;
   logic        hawk_inactive_i;
   logic        cpu_req_valid_i;
   logic        cpu_req_ready_o;
   logic        cpu_req_write_i;
   logic [31:0] cpu_req_addr_i;
   logic [63:0] cpu_req_data_i;
   logic        cpu_rsp_valid_o;
   logic        cpu_rsp_ready_i;
   logic [63:0] cpu_rsp_data_o;
   logic        mem_req_valid_o;
   logic        mem_req_ready_i;
   logic        mem_req_write_o;
   logic [31:0] mem_req_addr_o;
   logic [63:0] mem_req_data_o;
   logic        mem_rsp_valid_i;
   logic        mem_rsp_ready_o;
   logic [63:0] mem_rsp_data_i;
   logic        init_done_o;

   int          cycle_cnt = 0;
   int          phase;                      // 1 = hawk active, 2 = inactive
   int          bringup_writes = 0;         // hawk requests seen in phase 1
   int          mem_rsp_cnt = 0;
   logic        done_seen = 1'b0;
   logic        cpu_seen = 1'b0;
   logic [63:0] backing_mem [logic [31:0]]; // memory model contents
   logic [63:0] ref_mem [logic [31:0]];     // expected contents
   logic [63:0] rsp_data_q [$];             // model responses in flight
   int          rsp_due_q [$];
   logic        exp_write_q [$];            // expected cpu requests at memory
   logic [31:0] exp_addr_q [$];
   logic [63:0] exp_data_q [$];
   logic        exp_rd_q [$];               // expected cpu responses
   logic [63:0] exp_rd_data_q [$];

   hacd_core dut_i (.*);

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   //////////////////////////////////////////////////////////////////////
   // reference rules
   function automatic logic [31:0] ref_mem_addr(input logic [31:0] a, input logic uart);
      return uart ? a : a - 32'h8000_0000;   // dram rebase
   endfunction

   function automatic logic [31:0] ref_init_addr(input int k);
      if (k < 16) return 32'h0001_0000 + 32'(k) * 8;   // att line
      return 32'h0002_0000 + 32'(k - 16) * 8;          // free list line
   endfunction

   function automatic logic [63:0] ref_init_data(input int k);
      if (k < 16) return '0;
      if (k == 31) return '1;                 // end of list
      return 64'(k - 16 + 1);                 // next free line
   endfunction

   function automatic logic [63:0] fill_word(input logic [31:0] a);
      return {a ^ 32'hc3a5_5a3c, ~a};         // unwritten memory
   endfunction

   task automatic end_with_failure();
      $display("Simulation FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("ERR %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
         end_with_failure();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // memory model and response back-pressure
   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         end_with_failure();
      end
      if (dut_i.u_mem_mux.u_mux_assertions.prop_failed) begin
         $display("a bound protocol assertion failed by %0t", $time);
         end_with_failure();
      end
   end

   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         rsp_data_q.delete();
         rsp_due_q.delete();
         mem_rsp_valid_i <= 1'b0;
      end else begin
         if (mem_rsp_valid_i && mem_rsp_ready_o) begin
            void'(rsp_data_q.pop_front());
            void'(rsp_due_q.pop_front());
         end
         if (mem_req_valid_o && mem_req_ready_i) begin
            if (mem_req_write_o) begin
               backing_mem[mem_req_addr_o] = mem_req_data_o;
               rsp_data_q.push_back({$urandom, $urandom});   // ignored by the cpu
            end else if (backing_mem.exists(mem_req_addr_o)) begin
               rsp_data_q.push_back(backing_mem[mem_req_addr_o]);
            end else begin
               rsp_data_q.push_back(fill_word(mem_req_addr_o));
            end
            rsp_due_q.push_back(cycle_cnt + $urandom_range(0, 6));
         end
         if (rsp_data_q.size() != 0 && rsp_due_q[0] <= cycle_cnt) begin
            mem_rsp_valid_i <= 1'b1;               // held until taken
            mem_rsp_data_i  <= rsp_data_q[0];
         end else begin
            mem_rsp_valid_i <= 1'b0;
         end
      end
      mem_req_ready_i <= ($urandom_range(0, 3) != 0);
      cpu_rsp_ready_i <= ($urandom_range(0, 3) != 0);
   end

   //////////////////////////////////////////////////////////////////////
   // compare process
   always @(posedge clk_i) begin : compare
      logic [31:0] a;
      if (rst_n_i) begin
         if (phase == 1 && init_done_o && !done_seen) begin
            check_value("bring-up responses at init_done_o rise", mem_rsp_cnt, 32);
            done_seen = 1'b1;
         end
         if (phase == 2) check_value("init_done_o in inactive mode", init_done_o, 1'b0);
         if (cpu_req_valid_i && cpu_req_ready_o) begin
            a = ref_mem_addr(cpu_req_addr_i, uart_boot_en_i);
            exp_write_q.push_back(cpu_req_write_i);
            exp_addr_q.push_back(a);
            exp_data_q.push_back(cpu_req_data_i);
            exp_rd_q.push_back(!cpu_req_write_i);
            if (cpu_req_write_i) begin
               ref_mem[a] = cpu_req_data_i;
               exp_rd_data_q.push_back('0);
            end else begin
               exp_rd_data_q.push_back(ref_mem.exists(a) ? ref_mem[a] : fill_word(a));
            end
         end
         if (mem_req_valid_o && mem_req_ready_i) begin
            if (phase == 1 &&
                (exp_addr_q.size() == 0 || mem_req_addr_o != exp_addr_q[0])) begin
               if (bringup_writes >= 32) begin
                  $display("an unexpected memory request appeared at %0t", $time);
                  end_with_failure();
               end else begin
                  check_value("bring-up write flag", mem_req_write_o, 1'b1);
                  check_value("bring-up address", mem_req_addr_o,
                              ref_init_addr(bringup_writes));
                  check_value("bring-up data", mem_req_data_o,
                              ref_init_data(bringup_writes));
                  bringup_writes++;
               end
            end else if (exp_addr_q.size() == 0) begin
               $display("a memory request appeared at %0t with no cpu request pending", $time);
               end_with_failure();
            end else begin
               if (phase == 1 && !cpu_seen) begin
                  check_value("hawk requests before first cpu request", bringup_writes, 32);
                  cpu_seen = 1'b1;
               end
               if (phase == 1) check_value("init_done_o at cpu request", init_done_o, 1'b1);
               check_value("cpu write flag at memory", mem_req_write_o, exp_write_q[0]);
               check_value("cpu address at memory", mem_req_addr_o, exp_addr_q[0]);
               if (exp_write_q[0]) check_value("cpu write data", mem_req_data_o, exp_data_q[0]);
               void'(exp_write_q.pop_front());
               void'(exp_addr_q.pop_front());
               void'(exp_data_q.pop_front());
            end
         end
         if (mem_rsp_valid_i && mem_rsp_ready_o) mem_rsp_cnt++;
         if (cpu_rsp_valid_o && cpu_rsp_ready_i) begin
            if (exp_rd_q.size() == 0) begin
               $display("a cpu response appeared at %0t with no request outstanding", $time);
               end_with_failure();
            end else begin
               if (exp_rd_q[0]) check_value("cpu read data", cpu_rsp_data_o, exp_rd_data_q[0]);
               void'(exp_rd_q.pop_front());
               void'(exp_rd_data_q.pop_front());
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus
   task automatic apply_reset(input int new_phase);
      rst_n_i <= 1'b0;
      @(posedge clk_i);
      phase = new_phase;                      // compare idle while in reset
      repeat (7) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      check_value("mem_req_valid_o after reset", mem_req_valid_o, 1'b0);
      check_value("cpu_rsp_valid_o after reset", cpu_rsp_valid_o, 1'b0);
      check_value("init_done_o after reset", init_done_o, 1'b0);
      check_value("cpu_req_ready_o after reset", cpu_req_ready_o, 1'b1);
      @(posedge clk_i);
   endtask

   task automatic run_cpu_traffic(input int n, input logic [31:0] base);
      int i;
      for (i = 0; i < n; i++) begin
         cpu_req_valid_i <= 1'b1;
         cpu_req_write_i <= $urandom_range(0, 1);
         cpu_req_addr_i  <= base + 32'($urandom_range(0, 15)) * 8;   // 16 line window
         cpu_req_data_i  <= {$urandom, $urandom};
         do @(posedge clk_i); while (!cpu_req_ready_o);
         cpu_req_valid_i <= 1'b0;
         repeat ($urandom_range(0, 2)) @(posedge clk_i);
      end
      do @(negedge clk_i); while (exp_rd_q.size() != 0);   // drain responses
      @(posedge clk_i);
   endtask

   initial begin : main
      void'($urandom(32'ha74fa7e8));
      rst_n_i         = 1'b0;
      uart_boot_en_i  = 1'b0;
      hawk_inactive_i = 1'b0;
      cpu_req_valid_i = 1'b0;
      cpu_req_write_i = 1'b0;
      cpu_req_addr_i  = '0;
      cpu_req_data_i  = '0;
      cpu_rsp_ready_i = 1'b0;
      mem_req_ready_i = 1'b0;
      mem_rsp_valid_i = 1'b0;
      mem_rsp_data_i  = '0;
      phase           = 1;
      @(posedge clk_i);
      apply_reset(1);
      run_cpu_traffic(N_TRANS, 32'h8000_1000);   // starts during bring-up
      hawk_inactive_i <= 1'b1;
      uart_boot_en_i  <= 1'b1;
      apply_reset(2);
      run_cpu_traffic(N_TRANS, 32'h0000_1000);   // same lines, raw addresses
      if (exp_addr_q.size() == 0 && bringup_writes == 32 &&
          done_seen && !dut_i.u_mem_mux.u_mux_assertions.prop_failed) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         $display("traffic left outstanding or a bound assertion failed");
         end_with_failure();
      end
   end

endmodule

`default_nettype wire

// ==== testbench/hacd_core_assertions.sv ====
//////////////////////////////////////////////////////////////////////
// hacd memory port protocol assertions
// request stable under stall, no response without an owner,
// outstanding requests capped by the owner queue depth
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module hacd_core_assertions (
   input wire                        clk_i,
   input wire                        rst_n_i,
   input wire                        mem_req_valid_i,
   input wire                        mem_req_ready_i,
   input wire                        mem_req_write_i,
   input wire [hacd_pkg::ADDR_W-1:0] mem_req_addr_i,
   input wire [hacd_pkg::DATA_W-1:0] mem_req_data_i,
   input wire                        mem_rsp_valid_i,
   input wire                        mem_rsp_ready_i,
   input wire                        own_empty_i
);

   logic [3:0] outstanding;          // accepted requests awaiting a response
   logic       prop_failed = 1'b0;   // sticky, watched by the testbench
   logic       req_fire;
   logic       rsp_fire;

   assign req_fire = mem_req_valid_i & mem_req_ready_i;
   assign rsp_fire = mem_rsp_valid_i & mem_rsp_ready_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         outstanding <= '0;
      end else begin
         if (req_fire && !rsp_fire) outstanding <= outstanding + 1'b1;
         if (rsp_fire && !req_fire) outstanding <= outstanding - 1'b1;
      end
   end

   req_stable_while_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i &&
      $stable({mem_req_write_i, mem_req_addr_i, mem_req_data_i}))
      else begin
         $error("memory request dropped or changed while stalled");
         prop_failed = 1'b1;
      end

   rsp_needs_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_rsp_valid_i |-> !own_empty_i)
      else begin
         $error("memory response offered with owner queue empty");
         prop_failed = 1'b1;
      end

   outstanding_capped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      outstanding <= 4'(hacd_pkg::FIFO_DEPTH))
      else begin
         $error("more requests outstanding than the owner queue holds");
         prop_failed = 1'b1;
      end

endmodule

bind hacd_mem_mux hacd_core_assertions u_mux_assertions (
   .clk_i           (clk_i),
   .rst_n_i         (rst_n_i),
   .mem_req_valid_i (mem_req_valid_o),
   .mem_req_ready_i (mem_req_ready_i),
   .mem_req_write_i (mem_req_write_o),
   .mem_req_addr_i  (mem_req_addr_o),
   .mem_req_data_i  (mem_req_data_o),
   .mem_rsp_valid_i (mem_rsp_valid_i),
   .mem_rsp_ready_i (mem_rsp_ready_o),
   .own_empty_i     (own_empty)
);

`default_nettype wire

// ==== source/hacd_core.sv ====
//////////////////////////////////////////////////////////////////////
// hacd core top level
// cpu stall unit, bring-up control unit and memory port selector
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module hacd_core (
   input  wire                         clk_i,
   input  wire                         rst_n_i,
   input  wire                         uart_boot_en_i,
   input  wire                         hawk_inactive_i,

   // cpu port
   input  wire                         cpu_req_valid_i,
   output logic                        cpu_req_ready_o,
   input  wire                         cpu_req_write_i,
   input  wire [hacd_pkg::ADDR_W-1:0]  cpu_req_addr_i,
   input  wire [hacd_pkg::DATA_W-1:0]  cpu_req_data_i,
   output logic                        cpu_rsp_valid_o,
   input  wire                         cpu_rsp_ready_i,
   output logic [hacd_pkg::DATA_W-1:0] cpu_rsp_data_o,

   // memory controller port
   output logic                        mem_req_valid_o,
   input  wire                         mem_req_ready_i,
   output logic                        mem_req_write_o,
   output logic [hacd_pkg::ADDR_W-1:0] mem_req_addr_o,
   output logic [hacd_pkg::DATA_W-1:0] mem_req_data_o,
   input  wire                         mem_rsp_valid_i,
   output logic                        mem_rsp_ready_o,
   input  wire [hacd_pkg::DATA_W-1:0]  mem_rsp_data_i,

   output logic                        init_done_o
);

   logic                        cpu_release;   // cu lets cpu queue drain
   logic                        q_valid;
   logic                        q_ready;
   hacd_pkg::mem_req_t          q_req;
   logic                        hk_req_valid;
   logic                        hk_req_ready;
   logic                        hk_req_write;
   logic [hacd_pkg::ADDR_W-1:0] hk_req_addr;
   logic [hacd_pkg::DATA_W-1:0] hk_req_data;
   logic                        hk_rsp_valid;

   hacd_cpu_stall u_cpu_stall (
      .clk_i, .rst_n_i, .uart_boot_en_i,
      .cpu_release_i (cpu_release),
      .cpu_req_valid_i, .cpu_req_write_i, .cpu_req_addr_i, .cpu_req_data_i,
      .cpu_req_ready_o,
      .q_valid_o (q_valid), .q_req_o (q_req), .q_ready_i (q_ready)
   );

   hacd_ctrl_unit u_ctrl_unit (
      .clk_i, .rst_n_i, .hawk_inactive_i,
      .hk_req_valid_o (hk_req_valid), .hk_req_write_o (hk_req_write),
      .hk_req_addr_o (hk_req_addr), .hk_req_data_o (hk_req_data),
      .hk_req_ready_i (hk_req_ready), .hk_rsp_valid_i (hk_rsp_valid),
      .cpu_release_o (cpu_release), .init_done_o
   );

   hacd_mem_mux u_mem_mux (
      .clk_i, .rst_n_i,
      .hk_req_valid_i (hk_req_valid), .hk_req_write_i (hk_req_write),
      .hk_req_addr_i (hk_req_addr), .hk_req_data_i (hk_req_data),
      .hk_req_ready_o (hk_req_ready), .hk_rsp_valid_o (hk_rsp_valid),
      .q_valid_i (q_valid), .q_req_i (q_req), .q_ready_o (q_ready),
      .cpu_rsp_valid_o, .cpu_rsp_data_o, .cpu_rsp_ready_i,
      .mem_req_valid_o, .mem_req_write_o, .mem_req_addr_o, .mem_req_data_o,
      .mem_req_ready_i, .mem_rsp_valid_i, .mem_rsp_data_i, .mem_rsp_ready_o
   );

endmodule

`default_nettype wire

// ==== source/hacd_mem_mux.sv ====
//////////////////////////////////////////////////////////////////////
// hacd memory port selector
// merges hawk and cpu requests onto one memory port, hawk first,
// and steers in-order responses back through an owner queue
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module hacd_mem_mux (
   input  wire                         clk_i,
   input  wire                         rst_n_i,

   // hawk side
   input  wire                         hk_req_valid_i,
   input  wire                         hk_req_write_i,
   input  wire [hacd_pkg::ADDR_W-1:0]  hk_req_addr_i,
   input  wire [hacd_pkg::DATA_W-1:0]  hk_req_data_i,
   output logic                        hk_req_ready_o,
   output logic                        hk_rsp_valid_o,

   // cpu queue side
   input  wire                         q_valid_i,
   input  wire hacd_pkg::mem_req_t     q_req_i,
   output logic                        q_ready_o,

   // cpu response
   output logic                        cpu_rsp_valid_o,
   output logic [hacd_pkg::DATA_W-1:0] cpu_rsp_data_o,
   input  wire                         cpu_rsp_ready_i,

   // memory side
   output logic                        mem_req_valid_o,
   output logic                        mem_req_write_o,
   output logic [hacd_pkg::ADDR_W-1:0] mem_req_addr_o,
   output logic [hacd_pkg::DATA_W-1:0] mem_req_data_o,
   input  wire                         mem_req_ready_i,
   input  wire                         mem_rsp_valid_i,
   input  wire [hacd_pkg::DATA_W-1:0]  mem_rsp_data_i,
   output logic                        mem_rsp_ready_o
);

   hacd_pkg::owner_t own_head;    // owner of oldest outstanding request
   hacd_pkg::owner_t own_in;
   logic             own_full;
   logic             own_empty;
   logic             can_issue;
   logic             head_cpu;
   logic             head_hawk;

   //////////////////////////////////////////////////////////////////////
   // request select, hawk wins
   assign can_issue       = ~own_full;             // caps outstanding requests
   assign mem_req_valid_o = can_issue & (hk_req_valid_i | q_valid_i);
   assign mem_req_write_o = hk_req_valid_i ? hk_req_write_i : q_req_i.write;
   assign mem_req_addr_o  = hk_req_valid_i ? hk_req_addr_i : q_req_i.addr;
   assign mem_req_data_o  = hk_req_valid_i ? hk_req_data_i : q_req_i.data;
   assign hk_req_ready_o  = can_issue & mem_req_ready_i;
   assign q_ready_o       = can_issue & mem_req_ready_i & ~hk_req_valid_i;
   assign own_in          = hk_req_valid_i ? hacd_pkg::OWNER_HAWK : hacd_pkg::OWNER_CPU;

   //////////////////////////////////////////////////////////////////////
   // response routing
   assign head_cpu        = ~own_empty & (own_head == hacd_pkg::OWNER_CPU);
   assign head_hawk       = ~own_empty & (own_head == hacd_pkg::OWNER_HAWK);
   assign mem_rsp_ready_o = head_hawk | (head_cpu & cpu_rsp_ready_i);  // hawk never stalls
   assign cpu_rsp_valid_o = mem_rsp_valid_i & head_cpu;
   assign cpu_rsp_data_o  = mem_rsp_data_i;
   assign hk_rsp_valid_o  = mem_rsp_valid_i & head_hawk;

   hacd_fifo #(
      .payload_t (hacd_pkg::owner_t),
      .DEPTH     (hacd_pkg::FIFO_DEPTH)
   ) u_owner_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (mem_req_valid_o & mem_req_ready_i),  // accepted request
      .push_data_i (own_in),
      .pop_i       (mem_rsp_valid_i & mem_rsp_ready_o),  // accepted response
      .pop_data_o  (own_head),
      .full_o      (own_full),
      .empty_o     (own_empty)
   );

endmodule

`default_nettype wire

// ==== source/hacd_ctrl_unit.sv ====
//////////////////////////////////////////////////////////////////////
// hacd control unit
// after reset zeroes every translation table line, then links the
// free list (line i points to i+1, last line holds all ones) and
// releases the cpu once every write has been acknowledged
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module hacd_ctrl_unit (
   input  wire                         clk_i,
   input  wire                         rst_n_i,
   input  wire                         hawk_inactive_i,  // bypass, no bring-up

   // hawk request towards selector
   output logic                        hk_req_valid_o,
   output logic                        hk_req_write_o,
   output logic [hacd_pkg::ADDR_W-1:0] hk_req_addr_o,
   output logic [hacd_pkg::DATA_W-1:0] hk_req_data_o,
   input  wire                         hk_req_ready_i,

   // hawk response, always accepted
   input  wire                         hk_rsp_valid_i,

   // status
   output logic                        cpu_release_o,
   output logic                        init_done_o
);

   hacd_pkg::cu_state_t             state_q;
   hacd_pkg::cu_state_t             state_d;
   logic [hacd_pkg::INIT_CNT_W-1:0] iss_cnt;    // writes issued
   logic [hacd_pkg::INIT_CNT_W-1:0] rsp_cnt;    // writes acknowledged
   logic [hacd_pkg::INIT_CNT_W-1:0] list_idx;   // free list line
   logic                            hk_fire;
   logic                            last_rsp;

   assign hk_fire  = hk_req_valid_o & hk_req_ready_i;
   assign last_rsp = hk_rsp_valid_i &
                     (rsp_cnt == hacd_pkg::INIT_CNT_W'(hacd_pkg::INIT_LINES - 1));
   assign list_idx = iss_cnt - hacd_pkg::INIT_CNT_W'(hacd_pkg::ATT_LINES);

   //////////////////////////////////////////////////////////////////////
   // next state and request generation
   always_comb begin
      state_d        = state_q;
      hk_req_valid_o = 1'b0;
      hk_req_write_o = 1'b1;                       // bring-up only writes
      hk_req_addr_o  = hacd_pkg::ATT_BASE + hacd_pkg::ADDR_W'(iss_cnt) * hacd_pkg::LINE_BYTES;
      hk_req_data_o  = '0;                         // empty att entry
      case (state_q)
         hacd_pkg::CU_IDLE: begin
            if (!hawk_inactive_i) state_d = hacd_pkg::CU_INIT_ATT;
         end
         hacd_pkg::CU_INIT_ATT: begin
            hk_req_valid_o = 1'b1;
            if (hk_req_ready_i &&
                iss_cnt == hacd_pkg::INIT_CNT_W'(hacd_pkg::ATT_LINES - 1)) begin
               state_d = hacd_pkg::CU_INIT_LIST;   // last att line taken
            end
         end
         hacd_pkg::CU_INIT_LIST: begin
            hk_req_valid_o = (iss_cnt < hacd_pkg::INIT_CNT_W'(hacd_pkg::INIT_LINES));
            hk_req_addr_o  = hacd_pkg::LIST_BASE +
                             hacd_pkg::ADDR_W'(list_idx) * hacd_pkg::LINE_BYTES;
            if (list_idx == hacd_pkg::INIT_CNT_W'(hacd_pkg::LIST_LINES - 1)) begin
               hk_req_data_o = hacd_pkg::LIST_END;  // tail marker
            end else begin
               hk_req_data_o = hacd_pkg::DATA_W'(list_idx) + 1'b1;  // next free line
            end
            if (last_rsp) state_d = hacd_pkg::CU_READY;
         end
         default: state_d = state_q;               // ready until next reset
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // state and counters
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= hacd_pkg::CU_IDLE;
         iss_cnt <= '0;
         rsp_cnt <= '0;
      end else begin
         state_q <= state_d;
         if (hk_fire) iss_cnt <= iss_cnt + 1'b1;
         if (hk_rsp_valid_i) rsp_cnt <= rsp_cnt + 1'b1;
      end
   end

   assign init_done_o   = (state_q == hacd_pkg::CU_READY);
   assign cpu_release_o = init_done_o | hawk_inactive_i;  // inactive never holds the cpu

endmodule

`default_nettype wire

// ==== source/hacd_cpu_stall.sv ====
//////////////////////////////////////////////////////////////////////
// hacd cpu stall unit
// rebases cpu addresses into the memory controller space and
// parks cpu requests in a queue until the control unit lets
// them through
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module hacd_cpu_stall (
   input  wire                        clk_i,
   input  wire                        rst_n_i,
   input  wire                        uart_boot_en_i,   // skip dram rebase
   input  wire                        cpu_release_i,    // from control unit

   // cpu request side
   input  wire                        cpu_req_valid_i,
   input  wire                        cpu_req_write_i,
   input  wire [hacd_pkg::ADDR_W-1:0] cpu_req_addr_i,
   input  wire [hacd_pkg::DATA_W-1:0] cpu_req_data_i,
   output logic                       cpu_req_ready_o,

   // towards memory port selector
   output logic                       q_valid_o,
   output hacd_pkg::mem_req_t         q_req_o,
   input  wire                        q_ready_i
);

   hacd_pkg::mem_req_t in_req;   // rebased request into the queue
   logic               q_full;
   logic               q_empty;
   logic               q_push;
   logic               q_pop;

   always_comb begin
      in_req.write = cpu_req_write_i;
      in_req.data  = cpu_req_data_i;
      if (uart_boot_en_i) begin
         in_req.addr = cpu_req_addr_i;                        // boot image, raw address
      end else begin
         in_req.addr = cpu_req_addr_i - hacd_pkg::DRAM_BASE;  // dram offset
      end
   end

   assign cpu_req_ready_o = ~q_full;               // room in queue
   assign q_push          = cpu_req_valid_i & ~q_full;
   assign q_valid_o       = ~q_empty & cpu_release_i;  // held during bring-up
   assign q_pop           = q_valid_o & q_ready_i;

   hacd_fifo #(
      .payload_t (hacd_pkg::mem_req_t),
      .DEPTH     (hacd_pkg::FIFO_DEPTH)
   ) u_req_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (q_push),
      .push_data_i (in_req),
      .pop_i       (q_pop),
      .pop_data_o  (q_req_o),
      .full_o      (q_full),
      .empty_o     (q_empty)
   );

endmodule

`default_nettype wire

// ==== source/hacd_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// hacd small synchronous fifo
// circular buffer with read/write pointers and an entry count,
// payload type set by parameter, head visible combinationally
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module hacd_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 4
) (
   input  wire           clk_i,
   input  wire           rst_n_i,
   input  wire           push_i,       // dropped when full
   input  wire payload_t push_data_i,
   input  wire           pop_i,        // dropped when empty
   output payload_t      pop_data_o,   // head entry
   output logic          full_o,
   output logic          empty_o
);

   payload_t                   mem [DEPTH];  // storage array
   logic [$clog2(DEPTH)-1:0]   wr_ptr;
   logic [$clog2(DEPTH)-1:0]   rd_ptr;
   logic [$clog2(DEPTH+1)-1:0] count;
   logic                       do_push;
   logic                       do_pop;

   // wrap at DEPTH, works for non power of two depths too
   function automatic logic [$clog2(DEPTH)-1:0] ptr_next(input logic [$clog2(DEPTH)-1:0] p);
      return (p == $clog2(DEPTH)'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign do_push    = push_i & ~full_o;
   assign do_pop     = pop_i & ~empty_o;
   assign full_o     = (count == ($clog2(DEPTH+1))'(DEPTH));
   assign empty_o    = (count == '0);
   assign pop_data_o = mem[rd_ptr];                  // read straight off the array

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= ptr_next(wr_ptr);
         if (do_pop) rd_ptr <= ptr_next(rd_ptr);
         if (do_push && !do_pop) count <= count + 1'b1;  // net fill
         if (do_pop && !do_push) count <= count - 1'b1;  // net drain
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) mem[wr_ptr] <= push_data_i;
   end

endmodule

`default_nettype wire

// ==== source/hacd_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// hacd shared definitions
// bus widths, memory map of the bring-up tables, request and
// owner types, control unit state encoding
//////////////////////////////////////////////////////////////////////
`default_nettype none

package hacd_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths and memory map
   localparam int ADDR_W = 32;
   localparam int DATA_W = 64;

   localparam logic [ADDR_W-1:0] DRAM_BASE  = 32'h8000_0000;  // cpu view of dram start
   localparam logic [ADDR_W-1:0] LINE_BYTES = 32'd8;          // one table line
   localparam logic [ADDR_W-1:0] ATT_BASE   = 32'h0001_0000;  // translation table
   localparam logic [ADDR_W-1:0] LIST_BASE  = 32'h0002_0000;  // free list

   localparam int ATT_LINES  = 16;
   localparam int LIST_LINES = 16;
   localparam int INIT_LINES = ATT_LINES + LIST_LINES;        // total bring-up writes
   localparam int INIT_CNT_W = $clog2(INIT_LINES + 1);        // counts 0..INIT_LINES

   localparam logic [DATA_W-1:0] LIST_END = '1;               // tail of free list

   localparam int FIFO_DEPTH = 4;                             // cpu queue and owner queue

   //////////////////////////////////////////////////////////////////////
   // types
   typedef struct packed {
      logic              write;  // 1 = write, 0 = read
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;   // don't care on reads
   } mem_req_t;

   typedef enum logic {
      OWNER_HAWK = 1'b0,
      OWNER_CPU  = 1'b1
   } owner_t;

   typedef enum logic [1:0] {
      CU_IDLE      = 2'd0,
      CU_INIT_ATT  = 2'd1,
      CU_INIT_LIST = 2'd2,
      CU_READY     = 2'd3
   } cu_state_t;

endpackage

`default_nettype wire
